// File: csr_file.sv
/* Machine CSR file: mstatus, mtvec, mepc, mcause, mscratch, mcycle with RW/RS/RC commit. */

`include "rv_defs.svh"

module csr_file import rv_isa_pkg::*; import rv_pipe_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`RV_CSR_AW-1:0] csr_addr_i,
  input  csr_op_e               csr_op_i,
  input  logic [`RV_XLEN-1:0]   csr_wdata_i,
  input  logic                  commit_i,
  output logic [`RV_XLEN-1:0]   csr_rdata_o
);

  logic [`RV_XLEN-1:0] mstatus, mtvec, mepc, mcause, mscratch, mcycle;
  logic [`RV_XLEN-1:0] wr_val;
  logic                wr_en;

  always_comb begin
    case (csr_addr_i)
      CSR_MSTATUS:  csr_rdata_o = mstatus;
      CSR_MTVEC:    csr_rdata_o = mtvec;
      CSR_MEPC:     csr_rdata_o = mepc;
      CSR_MCAUSE:   csr_rdata_o = mcause;
      CSR_MSCRATCH: csr_rdata_o = mscratch;
      CSR_MCYCLE:   csr_rdata_o = mcycle;
      default:      csr_rdata_o = '0;
    endcase
  end

  always_comb begin
    case (csr_op_i)
      CSR_OP_RW: wr_val = csr_wdata_i;
      CSR_OP_RS: wr_val = csr_rdata_o | csr_wdata_i;
      CSR_OP_RC: wr_val = csr_rdata_o & ~csr_wdata_i;
      default:   wr_val = csr_rdata_o;
    endcase
  end

  // Set and clear with a zero mask are pure reads.
  assign wr_en = commit_i && (csr_op_i == CSR_OP_RW ||
                 (csr_op_i != CSR_OP_NONE && csr_wdata_i != '0));

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus  <= '0;
      mtvec    <= '0;
      mepc     <= '0;
      mcause   <= '0;
      mscratch <= '0;
      mcycle   <= '0;
    end else begin
      mcycle <= mcycle + 1'b1;  // Free running, software writes are dropped.
      if (wr_en) begin
        case (csr_addr_i)
          CSR_MSTATUS:  mstatus  <= wr_val;
          CSR_MTVEC:    mtvec    <= wr_val;
          CSR_MEPC:     mepc     <= wr_val;
          CSR_MCAUSE:   mcause   <= wr_val;
          CSR_MSCRATCH: mscratch <= wr_val;
          default: ;
        endcase
      end
    end
  end

  a_commit_op_known: assert property (@(posedge clk) disable iff (rst)
    commit_i |-> !$isunknown(csr_op_i));

endmodule

// File: id_decoder.sv
/* Combinational RV64I and Zicsr decoder producing operands, memory, CSR and control fields. */

`include "rv_defs.svh"

module id_decoder import rv_isa_pkg::*; import rv_pipe_pkg::*; (
  input  logic [`RV_ILEN-1:0]   inst_i,
  input  logic [`RV_XLEN-1:0]   pc_i,
  input  logic [`RV_XLEN-1:0]   pc_pred_i,
  input  logic [`RV_XLEN-1:0]   rs1_data_i,
  input  logic [`RV_XLEN-1:0]   rs2_data_i,
  input  logic [`RV_XLEN-1:0]   csr_rdata_i,
  output logic                  rs1_ren_o,
  output reg_idx_t              rs1_o,
  output logic                  rs2_ren_o,
  output reg_idx_t              rs2_o,
  output reg_idx_t              rd_o,
  output itype_e                itype_o,
  output opcode_e               opcode_o,
  output logic [2:0]            funct3_o,
  output logic [6:0]            funct7_o,
  output logic [`RV_XLEN-1:0]   op1_o,
  output logic [`RV_XLEN-1:0]   op2_o,
  output logic [`RV_XLEN-1:0]   t1_o,
  output logic                  mem_ren_o,
  output logic                  mem_wen_o,
  output logic [`RV_XLEN-1:0]   mem_addr_o,
  output logic [`RV_XLEN-1:0]   mem_wdata_o,
  output logic [`RV_CSR_AW-1:0] csr_addr_o,
  output csr_op_e               csr_op_o,
  output logic [`RV_XLEN-1:0]   csr_wdata_o,
  output logic [`RV_XLEN-1:0]   pc_pred_o,
  output logic                  skip_difftest_o
);

  opcode_e              opc;
  logic [2:0]           f3;
  logic                 known;
  logic [`RV_XLEN-1:0]  imm_i, imm_s, imm_b, imm_u, imm_j, zimm;

  assign opc = opcode_e'(inst_i[6:2]);
  assign f3  = inst_i[14:12];

  assign imm_i = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{(`RV_XLEN-12){inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{(`RV_XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                  inst_i[11:8], 1'b0};
  assign imm_u = {{(`RV_XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                  inst_i[30:21], 1'b0};
  assign zimm  = {{(`RV_XLEN-5){1'b0}}, inst_i[19:15]};

  always_comb begin
    rs1_ren_o       = 1'b0;
    rs1_o           = '0;
    rs2_ren_o       = 1'b0;
    rs2_o           = '0;
    rd_o            = '0;
    itype_o         = IT_NONE;
    opcode_o        = opcode_e'(5'b0);
    funct3_o        = '0;
    funct7_o        = '0;
    op1_o           = '0;
    op2_o           = '0;
    t1_o            = '0;
    mem_ren_o       = 1'b0;
    mem_wen_o       = 1'b0;
    mem_addr_o      = '0;
    mem_wdata_o     = '0;
    csr_addr_o      = '0;
    csr_op_o        = CSR_OP_NONE;
    csr_wdata_o     = '0;
    pc_pred_o       = '0;
    skip_difftest_o = 1'b0;
    known           = 1'b1;

    case (opc)
      OPC_OP_IMM, OPC_OP_IMM_32: begin
        itype_o   = IT_ALU;
        rs1_ren_o = 1'b1;
        op1_o     = rs1_data_i;
        op2_o     = imm_i;
      end
      OPC_OP, OPC_OP_32: begin
        itype_o   = IT_ALU;
        rs1_ren_o = 1'b1;
        rs2_ren_o = 1'b1;
        op1_o     = rs1_data_i;
        op2_o     = rs2_data_i;
      end
      OPC_LUI: begin
        itype_o = IT_ALU;
        op1_o   = imm_u;
      end
      OPC_AUIPC: begin
        itype_o = IT_ALU;
        op1_o   = pc_i;
        op2_o   = imm_u;
      end
      OPC_JAL: begin
        itype_o = IT_JUMP;
        op1_o   = pc_i;
        op2_o   = `RV_XLEN'd4;   // Link value is op1 + op2.
        t1_o    = pc_i + imm_j;
      end
      OPC_JALR: begin
        itype_o   = IT_JUMP;
        rs1_ren_o = 1'b1;
        op1_o     = pc_i;
        op2_o     = `RV_XLEN'd4;
        t1_o      = (rs1_data_i + imm_i) & ~`RV_XLEN'd1;
      end
      OPC_BRANCH: begin
        itype_o   = IT_BRANCH;
        rs1_ren_o = 1'b1;
        rs2_ren_o = 1'b1;
        op1_o     = rs1_data_i;
        op2_o     = rs2_data_i;
        t1_o      = pc_i + imm_b;
      end
      OPC_LOAD: begin
        itype_o    = IT_LOAD;
        rs1_ren_o  = 1'b1;
        mem_ren_o  = 1'b1;
        mem_addr_o = rs1_data_i + imm_i;
      end
      OPC_STORE: begin
        itype_o     = IT_STORE;
        rs1_ren_o   = 1'b1;
        rs2_ren_o   = 1'b1;
        mem_wen_o   = 1'b1;
        mem_addr_o  = rs1_data_i + imm_s;
        mem_wdata_o = rs2_data_i;
      end
      OPC_SYSTEM: begin
        if (f3 inside {F3_CSRRW, F3_CSRRS, F3_CSRRC, F3_CSRRWI, F3_CSRRSI, F3_CSRRCI}) begin
          itype_o         = IT_CSR;
          rs1_ren_o       = !f3[2];  // Immediate forms carry zimm in the rs1 field.
          csr_addr_o      = inst_i[31:20];
          csr_op_o        = csr_op_e'(f3[1:0]);
          csr_wdata_o     = f3[2] ? zimm : rs1_data_i;
          op1_o           = csr_rdata_i;
          skip_difftest_o = (inst_i[31:20] == CSR_MCYCLE);
        end else begin
          known = 1'b0;  // ecall, ebreak and friends are out of scope.
        end
      end
      default: known = 1'b0;
    endcase

    if (known) begin
      rs1_o     = rs1_ren_o ? inst_i[19:15] : '0;
      rs2_o     = rs2_ren_o ? inst_i[24:20] : '0;
      rd_o      = (itype_o == IT_STORE || itype_o == IT_BRANCH) ? '0 : inst_i[11:7];
      opcode_o  = opc;
      funct3_o  = f3;
      funct7_o  = inst_i[31:25];
      pc_pred_o = pc_pred_i;
    end
  end

  always_comb begin
    assert (!(mem_ren_o && mem_wen_o))
      else $error("Decoder raised mem_ren and mem_wen together.");
  end

endmodule

// File: id_stage.sv
/* Decode stage: one-entry holding register under the req/ack handshake around the decoder. */

`include "rv_defs.svh"

module id_stage import rv_isa_pkg::*; import rv_pipe_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  id_fetched_req_i,
  output logic                  id_fetched_ack_o,
  input  logic [`RV_ILEN-1:0]   inst_i,
  input  logic [`RV_XLEN-1:0]   pc_i,
  input  logic [`RV_XLEN-1:0]   pc_pred_i,
  output logic                  id_decoded_req_o,
  input  logic                  id_decoded_ack_i,
  input  logic [`RV_XLEN-1:0]   rs1_data_i,
  input  logic [`RV_XLEN-1:0]   rs2_data_i,
  input  logic [`RV_XLEN-1:0]   csr_rdata_i,
  output logic                  rs1_ren_o,
  output reg_idx_t              rs1_o,
  output logic                  rs2_ren_o,
  output reg_idx_t              rs2_o,
  output reg_idx_t              rd_o,
  output itype_e                itype_o,
  output opcode_e               opcode_o,
  output logic [2:0]            funct3_o,
  output logic [6:0]            funct7_o,
  output logic [`RV_XLEN-1:0]   op1_o,
  output logic [`RV_XLEN-1:0]   op2_o,
  output logic [`RV_XLEN-1:0]   t1_o,
  output logic                  mem_ren_o,
  output logic                  mem_wen_o,
  output logic [`RV_XLEN-1:0]   mem_addr_o,
  output logic [`RV_XLEN-1:0]   mem_wdata_o,
  output logic [`RV_CSR_AW-1:0] csr_addr_o,
  output csr_op_e               csr_op_o,
  output logic [`RV_XLEN-1:0]   csr_wdata_o,
  output logic                  csr_commit_o,
  output logic [`RV_XLEN-1:0]   pc_pred_o,
  output logic                  skip_difftest_o
);

  logic [`RV_ILEN-1:0] inst_q;
  logic [`RV_XLEN-1:0] pc_q;
  logic [`RV_XLEN-1:0] pc_pred_q;
  logic                fetched_hs;

  // Accept when empty or when the held item leaves this cycle.
  assign id_fetched_ack_o = !id_decoded_req_o || id_decoded_ack_i;
  assign fetched_hs       = id_fetched_req_i && id_fetched_ack_o;
  assign csr_commit_o     = id_decoded_req_o && id_decoded_ack_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      id_decoded_req_o <= 1'b0;
      inst_q           <= `RV_NOP;
    end else if (fetched_hs) begin
      id_decoded_req_o <= 1'b1;
      inst_q           <= inst_i;
    end else if (csr_commit_o) begin
      id_decoded_req_o <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fetched_hs) begin
      pc_q      <= pc_i;
      pc_pred_q <= pc_pred_i;
    end
  end

  id_decoder u_decoder (
    .inst_i         (inst_q),
    .pc_i           (pc_q),
    .pc_pred_i      (pc_pred_q),
    .rs1_data_i     (rs1_data_i),
    .rs2_data_i     (rs2_data_i),
    .csr_rdata_i    (csr_rdata_i),
    .rs1_ren_o      (rs1_ren_o),
    .rs1_o          (rs1_o),
    .rs2_ren_o      (rs2_ren_o),
    .rs2_o          (rs2_o),
    .rd_o           (rd_o),
    .itype_o        (itype_o),
    .opcode_o       (opcode_o),
    .funct3_o       (funct3_o),
    .funct7_o       (funct7_o),
    .op1_o          (op1_o),
    .op2_o          (op2_o),
    .t1_o           (t1_o),
    .mem_ren_o      (mem_ren_o),
    .mem_wen_o      (mem_wen_o),
    .mem_addr_o     (mem_addr_o),
    .mem_wdata_o    (mem_wdata_o),
    .csr_addr_o     (csr_addr_o),
    .csr_op_o       (csr_op_o),
    .csr_wdata_o    (csr_wdata_o),
    .pc_pred_o      (pc_pred_o),
    .skip_difftest_o(skip_difftest_o)
  );

  // Back-pressure must freeze the held item.
  a_hold_stable: assert property (@(posedge clk) disable iff (rst)
    id_decoded_req_o && !id_decoded_ack_i |=> $stable(inst_q));

  // The held item stays in place with its PC pair until it is taken.
  a_no_overwrite: assert property (@(posedge clk) disable iff (rst)
    id_decoded_req_o && !id_decoded_ack_i
      |=> id_decoded_req_o && $stable(pc_q) && $stable(pc_pred_q));

endmodule

// File: id_top.sv
/* Decode subsystem top: ID stage, integer register file and machine CSR file. */

`include "rv_defs.svh"

module id_top import rv_isa_pkg::*; import rv_pipe_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                id_fetched_req_i,
  output logic                id_fetched_ack_o,
  input  logic [`RV_ILEN-1:0] inst_i,
  input  logic [`RV_XLEN-1:0] pc_i,
  input  logic [`RV_XLEN-1:0] pc_pred_i,
  output logic                id_decoded_req_o,
  input  logic                id_decoded_ack_i,
  input  logic                wb_wen_i,
  input  reg_idx_t            wb_rd_i,
  input  logic [`RV_XLEN-1:0] wb_data_i,
  output reg_idx_t            rd_o,
  output itype_e              itype_o,
  output opcode_e             opcode_o,
  output logic [2:0]          funct3_o,
  output logic [6:0]          funct7_o,
  output logic [`RV_XLEN-1:0] op1_o,
  output logic [`RV_XLEN-1:0] op2_o,
  output logic [`RV_XLEN-1:0] t1_o,
  output logic                mem_ren_o,
  output logic                mem_wen_o,
  output logic [`RV_XLEN-1:0] mem_addr_o,
  output logic [`RV_XLEN-1:0] mem_wdata_o,
  output logic [`RV_XLEN-1:0] pc_pred_o,
  output logic                skip_difftest_o
);

  logic                  rs1_ren, rs2_ren;
  reg_idx_t              rs1, rs2;
  logic [`RV_XLEN-1:0]   rs1_data, rs2_data;
  logic [`RV_CSR_AW-1:0] csr_addr;
  csr_op_e               csr_op;
  logic [`RV_XLEN-1:0]   csr_wdata, csr_rdata;
  logic                  csr_commit;

  id_stage u_id_stage (
    .clk(clk), .rst(rst),
    .id_fetched_req_i(id_fetched_req_i),
    .id_fetched_ack_o(id_fetched_ack_o),
    .inst_i(inst_i), .pc_i(pc_i), .pc_pred_i(pc_pred_i),
    .id_decoded_req_o(id_decoded_req_o),
    .id_decoded_ack_i(id_decoded_ack_i),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data), .csr_rdata_i(csr_rdata),
    .rs1_ren_o(rs1_ren), .rs1_o(rs1), .rs2_ren_o(rs2_ren), .rs2_o(rs2),
    .rd_o(rd_o), .itype_o(itype_o), .opcode_o(opcode_o),
    .funct3_o(funct3_o), .funct7_o(funct7_o),
    .op1_o(op1_o), .op2_o(op2_o), .t1_o(t1_o),
    .mem_ren_o(mem_ren_o), .mem_wen_o(mem_wen_o),
    .mem_addr_o(mem_addr_o), .mem_wdata_o(mem_wdata_o),
    .csr_addr_o(csr_addr), .csr_op_o(csr_op), .csr_wdata_o(csr_wdata),
    .csr_commit_o(csr_commit),
    .pc_pred_o(pc_pred_o), .skip_difftest_o(skip_difftest_o)
  );

  reg_file u_reg_file (
    .clk(clk), .rst(rst),
    .rs1_ren_i(rs1_ren), .rs1_i(rs1), .rs2_ren_i(rs2_ren), .rs2_i(rs2),
    .wen_i(wb_wen_i), .rd_i(wb_rd_i), .wdata_i(wb_data_i),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data)
  );

  csr_file u_csr_file (
    .clk(clk), .rst(rst),
    .csr_addr_i(csr_addr), .csr_op_i(csr_op), .csr_wdata_i(csr_wdata),
    .commit_i(csr_commit), .csr_rdata_o(csr_rdata)
  );

endmodule

// File: reg_file.sv
/* Integer register file, 32 x 64, two combinational read ports and one write port. */

`include "rv_defs.svh"

module reg_file import rv_pipe_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                rs1_ren_i,
  input  reg_idx_t            rs1_i,
  input  logic                rs2_ren_i,
  input  reg_idx_t            rs2_i,
  input  logic                wen_i,
  input  reg_idx_t            rd_i,
  input  logic [`RV_XLEN-1:0] wdata_i,
  output logic [`RV_XLEN-1:0] rs1_data_o,
  output logic [`RV_XLEN-1:0] rs2_data_o
);

  logic [`RV_XLEN-1:0] regs [2**`RV_REG_AW];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 2**`RV_REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && rd_i != '0) begin
      regs[rd_i] <= wdata_i;  // x0 stays zero.
    end
  end

  // No write bypass, a same-cycle write shows up next cycle.
  assign rs1_data_o = rs1_ren_i ? regs[rs1_i] : '0;
  assign rs2_data_o = rs2_ren_i ? regs[rs2_i] : '0;

  a_x0_zero_rs1: assert property (@(posedge clk) disable iff (rst)
    rs1_ren_i && rs1_i == '0 |-> rs1_data_o == '0);

  a_x0_zero_rs2: assert property (@(posedge clk) disable iff (rst)
    rs2_ren_i && rs2_i == '0 |-> rs2_data_o == '0);

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds the decode subsystem testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_id_top; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_id_top)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1

// File: rv_defs.svh
/* Width and encoding macros shared by the RV64I decode subsystem. */

`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Data path width.
`define RV_XLEN 64

// Instruction width, compressed forms not supported.
`define RV_ILEN 32

`define RV_REG_AW 5   // 32 integer registers.

`define RV_CSR_AW 12  // Standard CSR address space.

// Canonical NOP, addi x0,x0,0.
`define RV_NOP 32'h0000_0013

`endif

// File: rv_isa_pkg.sv
/* ISA encodings: major opcode enum, Zicsr funct3 codes and machine CSR addresses. */

`include "rv_defs.svh"

package rv_isa_pkg;

  // Major opcode, instruction bits 6:2. Bits 1:0 are always 2'b11 for 32-bit forms.
  typedef enum logic [4:0] {
    OPC_LOAD      = 5'b00000,
    OPC_OP_IMM    = 5'b00100,
    OPC_AUIPC     = 5'b00101,
    OPC_OP_IMM_32 = 5'b00110,
    OPC_STORE     = 5'b01000,
    OPC_OP        = 5'b01100,
    OPC_LUI       = 5'b01101,
    OPC_OP_32     = 5'b01110,
    OPC_BRANCH    = 5'b11000,
    OPC_JALR      = 5'b11001,
    OPC_JAL       = 5'b11011,
    OPC_SYSTEM    = 5'b11100
  } opcode_e;

  // Zicsr funct3. Bit 2 selects the immediate form.
  localparam logic [2:0] F3_CSRRW  = 3'b001;
  localparam logic [2:0] F3_CSRRS  = 3'b010;
  localparam logic [2:0] F3_CSRRC  = 3'b011;
  localparam logic [2:0] F3_CSRRWI = 3'b101;
  localparam logic [2:0] F3_CSRRSI = 3'b110;
  localparam logic [2:0] F3_CSRRCI = 3'b111;

  // Machine mode CSRs implemented here.
  localparam logic [`RV_CSR_AW-1:0] CSR_MSTATUS  = 12'h300;
  localparam logic [`RV_CSR_AW-1:0] CSR_MTVEC    = 12'h305;
  localparam logic [`RV_CSR_AW-1:0] CSR_MSCRATCH = 12'h340;
  localparam logic [`RV_CSR_AW-1:0] CSR_MEPC     = 12'h341;
  localparam logic [`RV_CSR_AW-1:0] CSR_MCAUSE   = 12'h342;
  localparam logic [`RV_CSR_AW-1:0] CSR_MCYCLE   = 12'hB00;

endpackage

// File: rv_pipe_pkg.sv
/* Pipeline types: instruction class, CSR operation and register index. */

`include "rv_defs.svh"

package rv_pipe_pkg;

  // Class of a decoded instruction, used by execute to pick a unit.
  typedef enum logic [2:0] {
    IT_NONE   = 3'd0,
    IT_ALU    = 3'd1,
    IT_LOAD   = 3'd2,
    IT_STORE  = 3'd3,
    IT_BRANCH = 3'd4,
    IT_JUMP   = 3'd5,
    IT_CSR    = 3'd6
  } itype_e;

  // Matches funct3[1:0] of the Zicsr forms.
  typedef enum logic [1:0] {
    CSR_OP_NONE = 2'd0,
    CSR_OP_RW   = 2'd1,
    CSR_OP_RS   = 2'd2,
    CSR_OP_RC   = 2'd3
  } csr_op_e;

  typedef logic [`RV_REG_AW-1:0] reg_idx_t;

endpackage

// File: tb.f
+incdir+.
rv_isa_pkg.sv
rv_pipe_pkg.sv
id_decoder.sv
id_stage.sv
reg_file.sv
csr_file.sv
id_top.sv
tb_id_top.sv

// File: tb_ref_model.svh
/* Reference decode model of the testbench, with shadow register and CSR state. */

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

typedef struct packed {
  reg_idx_t            rd;
  itype_e              itype;
  opcode_e             opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] op1;
  logic [`RV_XLEN-1:0] op2;
  logic [`RV_XLEN-1:0] t1;
  logic                mem_ren;
  logic                mem_wen;
  logic [`RV_XLEN-1:0] mem_addr;
  logic [`RV_XLEN-1:0] mem_wdata;
  logic [`RV_XLEN-1:0] pc_pred;
  logic                skip;
  logic                op1_known;  // Low for mcycle reads, the counter is not modelled.
} exp_t;

logic [`RV_XLEN-1:0] sh_regs [32];
logic [`RV_XLEN-1:0] sh_mstatus, sh_mtvec, sh_mepc, sh_mcause, sh_mscratch;

function automatic void reset_shadow();
  for (int i = 0; i < 32; i++)
    sh_regs[i] = '0;
  sh_mstatus  = '0;
  sh_mtvec    = '0;
  sh_mepc     = '0;
  sh_mcause   = '0;
  sh_mscratch = '0;
endfunction

function automatic logic [`RV_XLEN-1:0] csr_value(input logic [`RV_CSR_AW-1:0] addr);
  case (addr)
    CSR_MSTATUS:  return sh_mstatus;
    CSR_MTVEC:    return sh_mtvec;
    CSR_MEPC:     return sh_mepc;
    CSR_MCAUSE:   return sh_mcause;
    CSR_MSCRATCH: return sh_mscratch;
    default:      return '0;
  endcase
endfunction

// Zicsr forms are the SYSTEM encodings with a nonzero funct3 low pair.
function automatic logic is_csr_inst(input logic [`RV_ILEN-1:0] w);
  return w[6:2] == OPC_SYSTEM && w[13:12] != 2'b00;
endfunction

function automatic exp_t ref_decode(input logic [`RV_ILEN-1:0] w,
                                    input logic [`RV_XLEN-1:0] pc,
                                    input logic [`RV_XLEN-1:0] pred);
  exp_t                e;
  logic                known;
  logic [`RV_XLEN-1:0] a, b, imm_i, imm_s, imm_b, imm_u, imm_j;
  a     = sh_regs[w[19:15]];
  b     = sh_regs[w[24:20]];
  imm_i = $signed(w[31:20]);
  imm_s = $signed({w[31:25], w[11:7]});
  imm_b = $signed({w[31], w[7], w[30:25], w[11:8], 1'b0});
  imm_u = $signed({w[31:12], 12'h000});
  imm_j = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
  e           = '0;
  e.op1_known = 1'b1;
  known       = 1'b1;
  case (w[6:2])
    OPC_OP_IMM, OPC_OP_IMM_32: begin
      e.itype = IT_ALU;
      e.op1   = a;
      e.op2   = imm_i;
    end
    OPC_OP, OPC_OP_32: begin
      e.itype = IT_ALU;
      e.op1   = a;
      e.op2   = b;
    end
    OPC_LUI: begin
      e.itype = IT_ALU;
      e.op1   = imm_u;
    end
    OPC_AUIPC: begin
      e.itype = IT_ALU;
      e.op1   = pc;
      e.op2   = imm_u;
    end
    OPC_JAL, OPC_JALR: begin
      e.itype = IT_JUMP;
      e.op1   = pc;
      e.op2   = 4;
      e.t1    = (w[6:2] == OPC_JAL) ? pc + imm_j : {a[63:1] + imm_i[63:1] + (a[0] & imm_i[0]), 1'b0};
    end
    OPC_BRANCH: begin
      e.itype = IT_BRANCH;
      e.op1   = a;
      e.op2   = b;
      e.t1    = pc + imm_b;
    end
    OPC_LOAD: begin
      e.itype    = IT_LOAD;
      e.mem_ren  = 1'b1;
      e.mem_addr = a + imm_i;
    end
    OPC_STORE: begin
      e.itype     = IT_STORE;
      e.mem_wen   = 1'b1;
      e.mem_addr  = a + imm_s;
      e.mem_wdata = b;
    end
    default: begin
      if (is_csr_inst(w)) begin
        e.itype     = IT_CSR;
        e.op1       = csr_value(w[31:20]);
        e.skip      = (w[31:20] == CSR_MCYCLE);
        e.op1_known = !e.skip;
      end else begin
        known = 1'b0;
      end
    end
  endcase
  if (known) begin
    e.rd      = (e.itype inside {IT_STORE, IT_BRANCH}) ? 5'd0 : w[11:7];
    e.opcode  = opcode_e'(w[6:2]);
    e.funct3  = w[14:12];
    e.funct7  = w[31:25];
    e.pc_pred = pred;
  end
  return e;
endfunction

// Mirrors the commit of a CSR instruction into the shadow CSRs.
function automatic void apply_csr_commit(input logic [`RV_ILEN-1:0] w);
  logic [`RV_XLEN-1:0] mask, old, nxt;
  if (!is_csr_inst(w))
    return;
  mask = w[14] ? {59'd0, w[19:15]} : sh_regs[w[19:15]];
  old  = csr_value(w[31:20]);
  case (w[13:12])
    2'b01:   nxt = mask;
    2'b10:   nxt = old | mask;
    default: nxt = old & ~mask;
  endcase
  if (w[13:12] != 2'b01 && mask == '0)
    return;  // Set or clear with an empty mask only reads.
  case (w[31:20])
    CSR_MSTATUS:  sh_mstatus  = nxt;
    CSR_MTVEC:    sh_mtvec    = nxt;
    CSR_MEPC:     sh_mepc     = nxt;
    CSR_MCAUSE:   sh_mcause   = nxt;
    CSR_MSCRATCH: sh_mscratch = nxt;
    default: ;
  endcase
endfunction

`endif

// File: tb_id_top.sv
/* Testbench for the decode subsystem: clock, reset, stimulus, reference compare and watchdog. */

`include "rv_defs.svh"

module tb_id_top import rv_isa_pkg::*; import rv_pipe_pkg::*; ();

  localparam int PERIOD       = 20;
  localparam int RESET_CYCLES = 10;
  localparam int N_REGS       = 32;
  localparam int N_ALU        = 40;
  localparam int N_MEM        = 24;
  localparam int N_JUMP       = 24;
  localparam int N_CSR        = 12;
  localparam int N_BP         = 48;
  localparam int N_TOTAL      = N_REGS + N_ALU + N_MEM + N_JUMP + N_CSR + N_BP;

  logic                clk, rst;
  logic                fetch_req, fetch_ack, dec_req;
  logic                dec_ack = 1'b1;
  logic [`RV_ILEN-1:0] f_inst;
  logic [`RV_XLEN-1:0] f_pc, f_pred;
  logic                wb_wen;
  reg_idx_t            wb_rd, rd;
  logic [`RV_XLEN-1:0] wb_data;
  itype_e              itype;
  opcode_e             opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] op1, op2, t1, mem_addr, mem_wdata, pc_pred;
  logic                mem_ren, mem_wen, skip;

  integer seed     = 32'he0ebfeef;
  integer ack_seed = 32'he0ebfeef ^ 32'h0000ffff;  // Own stream for downstream stalls.
  logic   bp_on    = 1'b0;
  int     checks = 0, errors = 0, n_tests = 0;
  int     test_checks, test_errors;

  `include "tb_ref_model.svh"

  exp_t exp_q [$];

  id_top dut0 (
    .clk(clk), .rst(rst),
    .id_fetched_req_i(fetch_req), .id_fetched_ack_o(fetch_ack),
    .inst_i(f_inst), .pc_i(f_pc), .pc_pred_i(f_pred),
    .id_decoded_req_o(dec_req), .id_decoded_ack_i(dec_ack),
    .wb_wen_i(wb_wen), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
    .rd_o(rd), .itype_o(itype), .opcode_o(opcode), .funct3_o(funct3), .funct7_o(funct7),
    .op1_o(op1), .op2_o(op2), .t1_o(t1),
    .mem_ren_o(mem_ren), .mem_wen_o(mem_wen), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata),
    .pc_pred_o(pc_pred), .skip_difftest_o(skip)
  );

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((N_TOTAL * 8 + RESET_CYCLES) * PERIOD);
    $display("Timeout: %0d instructions still outstanding", exp_q.size());
    $display("TEST FAIL");
    $finish;
  end

  task automatic check_word(input string name, input logic [`RV_XLEN-1:0] exp,
                            input logic [`RV_XLEN-1:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_index(input string name, input reg_idx_t exp, input reg_idx_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected x%0d, got x%0d", $time, name, exp, act);
    end
  endtask

  task automatic check_itype(input string name, input itype_e exp, input itype_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %s, got %s", $time, name, exp.name(), act.name());
    end
  endtask

  task automatic check_opcode(input string name, input opcode_e exp, input opcode_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic compare_outputs(input exp_t e);
    check_index("rd_o", e.rd, rd);
    check_itype("itype_o", e.itype, itype);
    check_opcode("opcode_o", e.opcode, opcode);
    check_word("funct3_o", e.funct3, funct3);
    check_word("funct7_o", e.funct7, funct7);
    if (e.op1_known)
      check_word("op1_o", e.op1, op1);
    check_word("op2_o", e.op2, op2);
    check_word("t1_o", e.t1, t1);
    check_word("mem_ren_o", e.mem_ren, mem_ren);
    check_word("mem_wen_o", e.mem_wen, mem_wen);
    check_word("mem_ren_o & mem_wen_o", 0, mem_ren & mem_wen);
    check_word("mem_addr_o", e.mem_addr, mem_addr);
    check_word("mem_wdata_o", e.mem_wdata, mem_wdata);
    check_word("pc_pred_o", e.pc_pred, pc_pred);
    check_word("skip_difftest_o", e.skip, skip);
  endtask

  // Every fetch transfer queues its expected decode.
  always @(posedge clk) begin
    if (!rst && fetch_req && fetch_ack) begin
      exp_q.push_back(ref_decode(f_inst, f_pc, f_pred));
      apply_csr_commit(f_inst);
    end
  end

  // The held item is checked on every cycle, stalled or not, and retired on ack.
  always @(posedge clk) begin
    if (!rst && dec_req) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Decoded request at %0t with no fetched instruction outstanding", $time);
      end else begin
        compare_outputs(exp_q[0]);
        if (dec_ack)
          void'(exp_q.pop_front());
      end
    end
  end

  always @(negedge clk) begin
    if (bp_on)
      dec_ack = ($random(ack_seed) & 3) != 0;
    else
      dec_ack = 1'b1;
  end

  function automatic logic [`RV_XLEN-1:0] rand_word();
    logic [31:0] hi, lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  function automatic logic [4:0] pick_opcode(input int kind, input logic [2:0] sel);
    if (kind == 1)
      return sel[0] ? OPC_LOAD : OPC_STORE;
    if (kind == 2)
      return (sel[1:0] == 2'd0) ? OPC_JAL : (sel[1:0] == 2'd1) ? OPC_JALR : OPC_BRANCH;
    case (sel)
      3'd0:    return OPC_OP;
      3'd1:    return OPC_OP_IMM;
      3'd2:    return OPC_OP_32;
      3'd3:    return OPC_OP_IMM_32;
      3'd4:    return OPC_LUI;
      3'd5:    return OPC_AUIPC;
      3'd6:    return OPC_OP_IMM;
      default: return 5'b00011;  // MISC-MEM, outside the decoded set.
    endcase
  endfunction

  function automatic logic [`RV_ILEN-1:0] csr_inst(input logic [2:0] f3,
                                                   input logic [`RV_CSR_AW-1:0] addr,
                                                   input logic [4:0] src);
    return {addr, src, f3, 5'd3, OPC_SYSTEM, 2'b11};
  endfunction

  task automatic send_inst(input logic [`RV_ILEN-1:0] w);
    logic [`RV_XLEN-1:0] pc, pred;
    pc   = rand_word() & ~64'h3;
    pred = pc[3] ? pc + 64'd4 : rand_word();
    @(negedge clk);
    fetch_req = 1'b1;
    f_inst    = w;
    f_pc      = pc;
    f_pred    = pred;
    @(posedge clk);
    while (!fetch_ack)
      @(posedge clk);
  endtask

  task automatic run_random(input int kind, input int n);
    logic [31:0] r, sel;
    int          k;
    for (int i = 0; i < n; i++) begin
      r   = $random(seed);
      sel = $random(seed);
      k   = (kind == 3) ? int'(sel[4:3]) % 3 : kind;
      send_inst({r[31:7], pick_opcode(k, sel[2:0]), 2'b11});
    end
  endtask

  task automatic write_reg(input reg_idx_t idx, input logic [`RV_XLEN-1:0] val);
    @(negedge clk);
    wb_wen  = 1'b1;
    wb_rd   = idx;
    wb_data = val;
    if (idx != 0)
      sh_regs[idx] = val;
  endtask

  task automatic begin_test();
    test_checks = checks;
    test_errors = errors;
  endtask

  // Once the stage drains, every fetched instruction must have been retired.
  task automatic end_test(input string name, input int n);
    @(negedge clk);
    fetch_req = 1'b0;
    @(posedge clk);
    while (dec_req)
      @(posedge clk);
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d fetched instructions never came out decoded", exp_q.size());
      exp_q.delete();
    end
    n_tests++;
    $display("test %s: %0d instructions, %0d checks, %0d errors", name, n,
             checks - test_checks, errors - test_errors);
  endtask

  initial begin
    rst       = 1'b1;
    fetch_req = 1'b0;
    f_inst    = `RV_NOP;
    f_pc      = '0;
    f_pred    = '0;
    wb_wen    = 1'b0;
    wb_rd     = '0;
    wb_data   = '0;
    reset_shadow();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    begin_test();
    @(posedge clk);
    check_word("id_decoded_req_o", 0, dec_req);
    check_word("id_fetched_ack_o", 1, fetch_ack);
    end_test("reset", 0);

    begin_test();
    for (int i = 0; i < N_REGS; i++)
      write_reg(reg_idx_t'(i), rand_word());
    @(negedge clk);
    wb_wen = 1'b0;
    run_random(0, N_ALU);
    end_test("alu", N_ALU);

    begin_test();
    run_random(1, N_MEM);
    end_test("load/store", N_MEM);

    begin_test();
    run_random(2, N_JUMP);
    end_test("jump/branch", N_JUMP);

    begin_test();
    send_inst(csr_inst(F3_CSRRW, CSR_MSCRATCH, 5'd5));
    send_inst(csr_inst(F3_CSRRS, CSR_MSCRATCH, 5'd6));
    send_inst(csr_inst(F3_CSRRC, CSR_MSCRATCH, 5'd7));
    send_inst(csr_inst(F3_CSRRS, CSR_MSCRATCH, 5'd0));
    send_inst(csr_inst(F3_CSRRWI, CSR_MEPC, 5'd21));
    send_inst(csr_inst(F3_CSRRSI, CSR_MEPC, 5'd10));
    send_inst(csr_inst(F3_CSRRCI, CSR_MEPC, 5'd3));
    send_inst(csr_inst(F3_CSRRCI, CSR_MEPC, 5'd0));
    send_inst(csr_inst(F3_CSRRS, CSR_MCYCLE, 5'd0));
    send_inst(csr_inst(F3_CSRRW, CSR_MSTATUS, 5'd8));
    send_inst(csr_inst(F3_CSRRC, CSR_MSTATUS, 5'd9));
    send_inst(csr_inst(F3_CSRRS, CSR_MSTATUS, 5'd0));
    end_test("csr", N_CSR);

    begin_test();
    bp_on = 1'b1;
    run_random(3, N_BP);
    end_test("back-pressure", N_BP);
    bp_on = 1'b0;

    $display("summary: %0d tests, %0d checks, %0d errors", n_tests, checks, errors);
    if (errors == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

endmodule
